/* Makefile */
TOP = gate_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+common
common/gate_pkg.sv
common/stream_if.sv
source/stream_fifo.sv
stream_gate/gate_core.sv
source/gate_top.sv
sim/gate_assertions.sv
sim/gate_tb.sv

/* common/gate_defs.svh */
/*
 * stream gate widths and queue depths
 */
`ifndef GATE_DEFS_SVH
`define GATE_DEFS_SVH

// ----------------------------------------------------------
// payload widths
// ----------------------------------------------------------
`define GATE_DATA_WIDTH   16
`define GATE_LEN_WIDTH    8     // permit length in plain beats
`define GATE_USER_WIDTH   4

// ----------------------------------------------------------
// queue depths
// ----------------------------------------------------------
`define GATE_PERMIT_DEPTH 4
`define GATE_BEAT_DEPTH   4

`endif

/* common/gate_pkg.sv */
/*
 * stream gate types
 * payload structs carried on the permit and beat streams
 */
`include "gate_defs.svh"

package gate_pkg;

    // ----------------------------------------------------------
    // scalar types
    // ----------------------------------------------------------
    typedef logic [`GATE_DATA_WIDTH-1:0] data_t;
    typedef logic [`GATE_LEN_WIDTH-1:0]  len_t;   // 1 .. 2**width-1
    typedef logic [`GATE_USER_WIDTH-1:0] user_t;

    // ----------------------------------------------------------
    // stream payloads
    // ----------------------------------------------------------

    // output frame length plus its tag
    typedef struct packed {
        len_t  len;
        user_t user;
    } permit_t;

    // last closes the input frame
    typedef struct packed {
        logic  last;
        data_t data;
    } beat_t;

endpackage

/* common/stream_if.sv */
/*
 * valid/ready stream with a typed payload
 */
`timescale 1ns/1ps

interface stream_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     ready;
    payload_t payload;    // stable while valid waits for ready

    // producer side
    modport source (
        output valid,
        output payload,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

/* sim/gate_assertions.sv */
/*
 * output stream protocol assertions for the stream gate
 */
`timescale 1ns/1ps

module gate_assertions (
    input logic            clk,
    input logic            reset,
    input logic            m_valid,
    input logic            m_ready,
    input logic            m_first,
    input logic            m_last,
    input gate_pkg::data_t m_data,
    input gate_pkg::user_t m_user
);

    logic expect_first;   // next accepted beat opens a frame

    always_ff @(posedge clk) begin
        if (reset) begin
            expect_first <= 1'b1;
        end else if (m_valid && m_ready) begin
            expect_first <= m_last;
        end
    end

    // ----------------------------------------------------------
    // properties
    // ----------------------------------------------------------
    assert property (@(posedge clk) reset |=> !m_valid)
        else $error("m_valid high during reset");

    // stalled beat holds until taken
    assert property (@(posedge clk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_first)
                                   && $stable(m_last) && $stable(m_user)))
        else $error("output beat changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        (m_valid && m_ready) |-> (m_first == expect_first))
        else $error("m_first does not follow the previous m_last");

endmodule

/* sim/gate_tb.sv */
/*
 * stream gate testbench
 * drives a frame table through permits and input frames and checks against a model queue
 */
`timescale 1ns/1ps
`include "gate_defs.svh"

module gate_tb;

    import gate_pkg::*;

    typedef struct packed {
        len_t  len;         // permit length
        user_t user;
        int    frame_len;   // input beats
        data_t base;
        bit    bp;          // random m_ready
        int    skip_n;      // beats sent under skip first
    } row_t;

    typedef struct packed {
        data_t data;
        logic  first;
        logic  last;
        user_t user;
    } exp_t;

    localparam int    NUM_ROWS     = 10;
    localparam int    DRAIN_CYCLES = `GATE_BEAT_DEPTH + 2;
    localparam int    OUT_WAIT     = 200;
    localparam data_t PAD          = 16'h5a5a;

    row_t rows [NUM_ROWS] = '{
        '{8'd4, 4'h1, 4, 16'h0100, 1'b0, 0},   // matched
        '{8'd5, 4'h2, 2, 16'h0200, 1'b0, 0},   // short frame padded
        '{8'd3, 4'h3, 6, 16'h0300, 1'b0, 0},   // long frame with surplus dropped
        '{8'd4, 4'h4, 4, 16'h0400, 1'b0, 3},
        '{8'd1, 4'h5, 1, 16'h0500, 1'b0, 0},
        '{8'd1, 4'h6, 3, 16'h0600, 1'b1, 0},   // single beat permit with a long frame
        '{8'd6, 4'h7, 6, 16'h0700, 1'b1, 2},
        '{8'd7, 4'h8, 3, 16'h0800, 1'b1, 0},
        '{8'd2, 4'h9, 5, 16'h0900, 1'b1, 1},
        '{8'd8, 4'ha, 8, 16'h0a00, 1'b1, 0}
    };

    logic  clk = 1'b0;
    logic  reset;
    logic  skip;
    data_t padding_data;
    logic  s_last;
    data_t s_data;
    logic  s_valid;
    logic  s_ready;
    logic  m_first;
    logic  m_last;
    data_t m_data;
    user_t m_user;
    logic  m_valid;
    logic  m_ready;
    len_t  permit_len;
    user_t permit_user;
    logic  permit_valid;
    logic  permit_ready;

    bit   bp_on = 1'b0;
    exp_t exp_q [$];
    int   data_errors  = 0;
    int   user_errors  = 0;
    int   other_errors = 0;
    int   watchdog_cycles;

    always #20 clk = ~clk;

    gate_top gate_top_inst (
        .clk          (clk),
        .reset        (reset),
        .skip         (skip),
        .padding_data (padding_data),
        .s_last       (s_last),
        .s_data       (s_data),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .m_first      (m_first),
        .m_last       (m_last),
        .m_data       (m_data),
        .m_user       (m_user),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .permit_len   (permit_len),
        .permit_user  (permit_user),
        .permit_valid (permit_valid),
        .permit_ready (permit_ready)
    );

    bind gate_top gate_assertions gate_assertions_inst (
        .clk     (clk),
        .reset   (reset),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_first (m_first),
        .m_last  (m_last),
        .m_data  (m_data),
        .m_user  (m_user)
    );

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_beat(input data_t got, input data_t want,
                              input logic got_first, input logic want_first,
                              input logic got_last, input logic want_last);
        if (got !== want || got_first !== want_first || got_last !== want_last) begin
            $display("Mismatch at %0t: data %h first %b last %b, expected %h first %b last %b",
                     $time, got, got_first, got_last, want, want_first, want_last);
            data_errors++;
        end
    endtask

    task automatic check_user(input user_t got, input user_t want);
        if (got !== want) begin
            $display("Mismatch at %0t: user %h, expected %h", $time, got, want);
            user_errors++;
        end
    endtask

    // output monitor pops one model entry per accepted beat
    always @(posedge clk) begin
        exp_t e;
        if (!reset && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: output beat %h arrived with no beat expected",
                         $time, m_data);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                check_beat(m_data, e.data, m_first, e.first, m_last, e.last);
                check_user(m_user, e.user);
            end
        end
    end

    // m_ready high unless back-pressure randomizes it
    initial begin
        bit bp;
        m_ready = 1'b0;
        void'($urandom(32'hb3bf));
        forever begin
            @(posedge clk);
            bp = bp_on;
            @(negedge clk);
            m_ready = bp ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // ----------------------------------------------------------
    // model and drivers
    // ----------------------------------------------------------
    task automatic add_expected(input row_t r);
        exp_t e;
        for (int i = 0; i < int'(r.len); i++) begin
            e.data  = (i < r.frame_len) ? data_t'(r.base + i) : PAD;
            e.first = (i == 0);
            e.last  = (i == int'(r.len) - 1);
            e.user  = r.user;
            exp_q.push_back(e);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_permit(input len_t len, input user_t user);
        permit_len   = len;
        permit_user  = user;
        permit_valid = 1'b1;
        while (!permit_ready) @(negedge clk);
        @(negedge clk);
        permit_valid = 1'b0;
    endtask

    // leaves s_valid high for a back to back next beat
    task automatic send_beat(input data_t data, input logic last);
        s_data  = data;
        s_last  = last;
        s_valid = 1'b1;
        while (!s_ready) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic send_frame(input data_t base, input int n);
        for (int i = 0; i < n; i++) begin
            send_beat(data_t'(base + i), i == n - 1);
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    task automatic send_skipped(input int n);
        skip = 1'b1;
        for (int i = 0; i < n; i++) begin
            send_beat(data_t'(16'hf000 + i), i == n - 1);
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
        idle(DRAIN_CYCLES);     // let the beat queue empty
        skip = 1'b0;
    endtask

    task automatic wait_output();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < OUT_WAIT) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_row(input row_t r);
        bp_on = r.bp;
        if (r.skip_n > 0) begin
            send_skipped(r.skip_n);
        end
        add_expected(r);
        send_permit(r.len, r.user);
        send_frame(r.base, r.frame_len);
        wait_output();
        idle(DRAIN_CYCLES);
    endtask

    // permits queued ahead of their frames
    task automatic run_queued();
        bp_on = 1'b1;
        for (int i = 0; i < `GATE_PERMIT_DEPTH; i++) begin
            add_expected(rows[i]);
            send_permit(rows[i].len, rows[i].user);
        end
        for (int i = 0; i < `GATE_PERMIT_DEPTH; i++) begin
            send_frame(rows[i].base, rows[i].frame_len);
        end
        wait_output();
        idle(DRAIN_CYCLES);
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        int n_beats;
        reset        = 1'b1;
        skip         = 1'b0;
        padding_data = PAD;
        s_last       = 1'b0;
        s_data       = '0;
        s_valid      = 1'b0;
        permit_len   = '0;
        permit_user  = '0;
        permit_valid = 1'b0;

        n_beats = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            n_beats += int'(rows[i].len) + rows[i].frame_len + rows[i].skip_n;
        end
        for (int i = 0; i < `GATE_PERMIT_DEPTH; i++) begin
            n_beats += int'(rows[i].len) + rows[i].frame_len;
        end
        watchdog_cycles = n_beats * 8 + 200;

        fork
            begin
                repeat (watchdog_cycles) @(posedge clk);
                $display("Timeout: the run did not end within %0d cycles", watchdog_cycles);
                $display("Simulation finished: FAIL");
                $finish;
            end
        join_none

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        run_queued();

        if (exp_q.size() != 0) begin
            $display("Error: %0d expected output beats never arrived", exp_q.size());
            other_errors += exp_q.size();
        end

        $display("Errors: data %0d, user %0d, other %0d",
                 data_errors, user_errors, other_errors);
        if (data_errors + user_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* source/gate_top.sv */
/*
 * stream gate top level
 * permit and beat queues in front of the combiner
 */
`timescale 1ns/1ps
`include "gate_defs.svh"

module gate_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                skip,
    input  gate_pkg::data_t     padding_data,

    input  logic                s_last,
    input  gate_pkg::data_t     s_data,
    input  logic                s_valid,
    output logic                s_ready,

    output logic                m_first,
    output logic                m_last,
    output gate_pkg::data_t     m_data,
    output gate_pkg::user_t     m_user,
    output logic                m_valid,
    input  logic                m_ready,

    input  gate_pkg::len_t      permit_len,
    input  gate_pkg::user_t     permit_user,
    input  logic                permit_valid,
    output logic                permit_ready
);

    import gate_pkg::*;

    stream_if #(.payload_t(permit_t)) permit_in_if ();
    stream_if #(.payload_t(permit_t)) permit_q_if ();
    stream_if #(.payload_t(beat_t))   beat_in_if ();
    stream_if #(.payload_t(beat_t))   beat_q_if ();

    // ----------------------------------------------------------
    // port packing
    // ----------------------------------------------------------
    assign permit_in_if.valid   = permit_valid;
    assign permit_in_if.payload = '{len: permit_len, user: permit_user};
    assign permit_ready         = permit_in_if.ready;

    assign beat_in_if.valid   = s_valid;
    assign beat_in_if.payload = '{last: s_last, data: s_data};
    assign s_ready            = beat_in_if.ready;

    // ----------------------------------------------------------
    // queues and combiner
    // ----------------------------------------------------------
    stream_fifo #(
        .payload_t (permit_t),
        .DEPTH     (`GATE_PERMIT_DEPTH)
    ) permit_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .wr    (permit_in_if),
        .rd    (permit_q_if)
    );

    stream_fifo #(
        .payload_t (beat_t),
        .DEPTH     (`GATE_BEAT_DEPTH)
    ) beat_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .wr    (beat_in_if),
        .rd    (beat_q_if)
    );

    gate_core gate_core_inst (
        .clk          (clk),
        .reset        (reset),
        .skip         (skip),
        .padding_data (padding_data),
        .permit       (permit_q_if),
        .beat         (beat_q_if),
        .m_first      (m_first),
        .m_last       (m_last),
        .m_data       (m_data),
        .m_user       (m_user),
        .m_valid      (m_valid),
        .m_ready      (m_ready)
    );

endmodule

/* source/stream_fifo.sv */
/*
 * synchronous stream FIFO with a registered head stage
 * used for both the permit queue and the data beat queue
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    stream_if.sink   wr,
    stream_if.source rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    payload_t head_q;             // registered output word

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;      // words held in mem without the head
    logic             head_valid;

    logic push;
    logic load;
    logic mem_empty;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ----------------------------------------------------------
    // handshake
    // ----------------------------------------------------------
    assign push      = wr.valid && wr.ready;
    assign load      = !head_valid || rd.ready;   // head free next edge
    assign mem_empty = (count == '0);
    assign bypass    = load && mem_empty && push; // straight into head
    assign mem_wr    = push && !bypass;
    assign mem_rd    = load && !mem_empty;

    assign wr.ready   = (count != CNT_W'(DEPTH));
    assign rd.valid   = head_valid;
    assign rd.payload = head_q;

    // ----------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (mem_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (mem_wr && !mem_rd) begin
                count <= count + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                count <= count - 1'b1;
            end
            if (load) begin
                head_valid <= !mem_empty || push;
            end
        end
    end

    // storage and head register
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= wr.payload;
        end
        if (mem_rd) begin
            head_q <= mem[rd_ptr];
        end else if (bypass) begin
            head_q <= wr.payload;
        end
    end

endmodule

/* stream_gate/gate_core.sv */
/*
 * stream gate combiner
 * pairs permits with data beats, pads short frames, drops surplus beats
 */
`timescale 1ns/1ps

module gate_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                skip,
    input  gate_pkg::data_t     padding_data,
    stream_if.sink              permit,
    stream_if.sink              beat,
    output logic                m_first,
    output logic                m_last,
    output gate_pkg::data_t     m_data,
    output gate_pkg::user_t     m_user,
    output logic                m_valid,
    input  logic                m_ready
);

    import gate_pkg::*;

    len_t  cnt;           // beats emitted for the head permit
    logic  short_frame;   // input frame ended before the permit did
    logic  discard;       // drop input up to its next last

    permit_t head_permit;
    beat_t   head_beat;

    logic out_load;
    logic emit;
    logic emit_first;
    logic emit_last;
    logic use_input;
    logic skip_beat;
    logic drop_beat;

    assign head_permit = permit.payload;
    assign head_beat   = beat.payload;

    // ----------------------------------------------------------
    // pairing decision
    // ----------------------------------------------------------

    // output register is empty or being taken this cycle
    assign out_load = !m_valid || m_ready;

    // one output beat per cycle from input data or padding
    assign emit = out_load && permit.valid && !discard
               && (short_frame || beat.valid);

    assign emit_first = (cnt == '0);
    assign emit_last  = (cnt == len_t'(head_permit.len - len_t'(1)));
    assign use_input  = emit && !short_frame;

    // surplus of a long frame or idle skipping
    assign drop_beat = discard && beat.valid;
    assign skip_beat = !permit.valid && skip && !discard;

    assign beat.ready   = use_input || discard || skip_beat;
    assign permit.ready = emit && emit_last;      // retire on final beat

    // ----------------------------------------------------------
    // frame state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt         <= '0;
            short_frame <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (emit) begin
                if (emit_last) begin
                    cnt         <= '0;
                    short_frame <= 1'b0;
                    // frame still open when the permit ends
                    discard     <= !short_frame && !head_beat.last;
                end else begin
                    cnt <= cnt + 1'b1;
                    if (use_input && head_beat.last) begin
                        short_frame <= 1'b1;   // pad from here on
                    end
                end
            end
            if (drop_beat && head_beat.last) begin
                discard <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // output register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end else if (out_load) begin
            m_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            m_first <= emit_first;
            m_last  <= emit_last;
            m_user  <= head_permit.user;
            m_data  <= short_frame ? padding_data : head_beat.data;
        end
    end

endmodule
